// File: router_fifo.f
+incdir+testbench
source/router_pkg.sv
source/ram_memory.sv
source/fifo.sv
source/class_demux.sv
source/router_top.sv
testbench/router_tb.sv

// File: Bender.yml
package:
  name: router_fifo

sources:
  - files:
      - source/router_pkg.sv
      - source/ram_memory.sv
      - source/fifo.sv
      - source/class_demux.sv
      - source/router_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/router_tb.sv

// File: testbench/router_checks.svh
`ifndef ROUTER_CHECKS_SVH
`define ROUTER_CHECKS_SVH

// expected words per destination, oldest first
data_t exp_q0[$];
data_t exp_q1[$];

task automatic fail_run(input string line);
    $display("%s", line);
    $display("Some tests failed");
    $fatal(1, "router_tb stopped at the first error");
endtask

task automatic check_data(input data_t got, input data_t want, input string what);
    if (got !== want) begin
        fail_run($sformatf("FAILED at %0t ns: %s is %0h, expected %0h",
                           $time, what, got, want));
    end
endtask

task automatic check_count(input main_cnt_t got, input main_cnt_t want, input string what);
    if (got !== want) begin
        fail_run($sformatf("FAILED at %0t ns: %s is %0d, expected %0d",
                           $time, what, got, want));
    end
endtask

task automatic check_flag(input logic got, input logic want, input string what);
    if (got !== want) begin
        fail_run($sformatf("FAILED at %0t ns: %s is %b, expected %b",
                           $time, what, got, want));
    end
endtask

// packet accepted by the main FIFO
task automatic model_push(input packet_t pkt);
    if (pkt.dest) begin
        exp_q1.push_back(pkt.data);
    end else begin
        exp_q0.push_back(pkt.data);
    end
endtask

// word read from an output FIFO must be the oldest one for that dest
task automatic compare_output(input logic dest, input data_t got);
    data_t want;
    if (dest) begin
        if (exp_q1.size() == 0) fail_run("out1 returned a word that was never pushed");
        want = exp_q1.pop_front();
        check_data(got, want, "data_out1");
    end else begin
        if (exp_q0.size() == 0) fail_run("out0 returned a word that was never pushed");
        want = exp_q0.pop_front();
        check_data(got, want, "data_out0");
    end
endtask

`endif

// File: testbench/router_tb.sv
`timescale 1ns/1ns

module router_tb import router_pkg::*; ();

    logic      clk;
    logic      reset_L;
    logic      push_in;
    packet_t   packet_in;
    logic      pop0;
    logic      pop1;
    main_cnt_t main_almost_full_thr;
    main_cnt_t main_almost_empty_thr;
    out_cnt_t  out_almost_full_thr;
    out_cnt_t  out_almost_empty_thr;
    main_cnt_t main_count;
    logic      main_full;
    logic      main_empty;
    logic      main_almost_full;
    logic      main_almost_empty;
    logic      main_error;
    data_t     data_out0;
    data_t     data_out1;
    logic      out0_empty;
    logic      out1_empty;
    logic      out0_almost_empty;
    logic      out1_almost_empty;
    logic      out0_error;
    logic      out1_error;

    logic pend0;  // pop issued last cycle, word due now
    logic pend1;

    `include "router_checks.svh"

    router_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic collect_words();
        if (pend0) compare_output(1'b0, data_out0);
        if (pend1) compare_output(1'b1, data_out1);
        pend0 = 1'b0;
        pend1 = 1'b0;
    endtask

    function automatic packet_t random_packet();
        packet_t pkt;
        pkt.dest = 1'($urandom);
        pkt.data = data_t'($urandom);
        return pkt;
    endfunction

    task automatic check_reset_state();
        check_count(main_count, '0, "main_count after reset");
        check_flag(main_empty, 1'b1, "main_empty after reset");
        check_flag(out0_empty, 1'b1, "out0_empty after reset");
        check_flag(out1_empty, 1'b1, "out1_empty after reset");
        check_flag(main_full, 1'b0, "main_full after reset");
        check_flag(main_almost_full, 1'b0, "main_almost_full after reset");
        check_flag(main_almost_empty, 1'b0, "main_almost_empty after reset");
        check_flag(out0_almost_empty, 1'b0, "out0_almost_empty after reset");
        check_flag(out1_almost_empty, 1'b0, "out1_almost_empty after reset");
        check_flag(main_error, 1'b0, "main_error after reset");
        check_flag(out0_error, 1'b0, "out0_error after reset");
        check_flag(out1_error, 1'b0, "out1_error after reset");
        check_data(data_out0, '0, "data_out0 after reset");
        check_data(data_out1, '0, "data_out1 after reset");
    endtask

    // pushes only while main is not full, pops only non-empty outputs
    task automatic random_traffic(input int n);
        int      pushed;
        int      cycles;
        packet_t pkt;
        pushed = 0;
        cycles = 0;
        while (pushed < n) begin
            @(negedge clk);
            collect_words();
            cycles++;
            if (cycles > n * 20) fail_run("random traffic did not push all packets in time");
            push_in = 1'b0;
            if (!main_full && (($urandom % 4) != 0)) begin
                pkt = random_packet();
                packet_in = pkt;
                push_in = 1'b1;
                model_push(pkt);
                pushed++;
            end
            pop0 = !out0_empty && (($urandom % 2) == 0);
            pop1 = !out1_empty && (($urandom % 2) == 0);
            pend0 = pop0;
            pend1 = pop1;
        end
        @(negedge clk);
        collect_words();
        push_in = 1'b0;
        pop0 = 1'b0;
        pop1 = 1'b0;
    endtask

    task automatic drain_all();
        int cycles;
        cycles = 0;
        push_in = 1'b0;
        while (1) begin
            @(negedge clk);
            collect_words();
            if (main_empty && out0_empty && out1_empty &&
                exp_q0.size() == 0 && exp_q1.size() == 0) break;
            cycles++;
            if (cycles > 200) fail_run("the FIFOs did not drain within 200 cycles");
            pop0 = !out0_empty;
            pop1 = !out1_empty;
            pend0 = pop0;
            pend1 = pop1;
        end
        pop0 = 1'b0;
        pop1 = 1'b0;
    endtask

    // outputs stall at almost full, so the main FIFO fills up
    task automatic overflow_main();
        int      cycles;
        packet_t pkt;
        cycles = 0;
        pop0 = 1'b0;
        pop1 = 1'b0;
        while (!main_full) begin
            cycles++;
            if (cycles > 200) fail_run("main FIFO did not fill within 200 cycles");
            pkt = random_packet();
            packet_in = pkt;
            push_in = 1'b1;
            model_push(pkt);
            @(negedge clk);
        end
        packet_in = random_packet();  // dropped, kept out of the model
        push_in = 1'b1;
        #1;
        check_flag(main_error, 1'b1, "main_error on push while full");
        @(negedge clk);
        push_in = 1'b0;
    endtask

    task automatic flags_at_rest();
        int rest_cnt;
        rest_cnt = main_depth;  // main FIFO left full by the overflow step
        repeat (20) begin
            @(negedge clk);
            check_count(main_count, main_cnt_t'(rest_cnt), "main_count at rest");
            check_flag(main_full, rest_cnt == main_depth, "main_full");
            check_flag(main_empty, rest_cnt == 0, "main_empty");
            check_flag(main_almost_full, rest_cnt >= int'(main_almost_full_thr),
                       "main_almost_full");
            check_flag(main_almost_empty,
                       (rest_cnt != 0) && (rest_cnt <= int'(main_almost_empty_thr)),
                       "main_almost_empty");
            check_flag(main_error, 1'b0, "main_error at rest");
        end
    endtask

    task automatic underflow_out0();
        data_t last;
        last = data_out0;
        check_flag(out0_empty, 1'b1, "out0_empty before underflow");
        check_flag(out1_empty, 1'b1, "out1_empty before underflow");
        pop0 = 1'b1;
        #1;
        check_flag(out0_error, 1'b1, "out0_error on pop while empty");
        @(negedge clk);
        pop0 = 1'b0;
        #1;
        check_flag(out0_error, 1'b0, "out0_error after underflow");
        check_flag(out0_empty, 1'b1, "out0_empty after underflow");
        check_data(data_out0, last, "data_out0 after underflow");
    endtask

    initial begin
        void'($urandom(32'hebdfa3f7));
        reset_L = 1'b0;
        push_in = 1'b0;
        packet_in = '0;
        pop0 = 1'b0;
        pop1 = 1'b0;
        main_almost_full_thr = main_cnt_t'(6);
        main_almost_empty_thr = main_cnt_t'(2);
        out_almost_full_thr = out_cnt_t'(3);  // one slot left for the word in flight
        out_almost_empty_thr = out_cnt_t'(1);
        pend0 = 1'b0;
        pend1 = 1'b0;
        repeat (2) @(negedge clk);
        reset_L = 1'b1;
        @(negedge clk);
        check_reset_state();

        random_traffic(200);
        drain_all();
        overflow_main();
        flags_at_rest();
        drain_all();
        underflow_out0();

        @(negedge clk);
        check_flag(main_empty, 1'b1, "main_empty at end");
        check_flag(out0_empty, 1'b1, "out0_empty at end");
        check_flag(out1_empty, 1'b1, "out1_empty at end");
        if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            fail_run("model still holds words that never came out");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

// File: source/router_top.sv
`timescale 1ns/1ns

module router_top import router_pkg::*; (
    input  logic      clk,
    input  logic      reset_L,
    input  logic      push_in,
    input  packet_t   packet_in,
    input  logic      pop0,
    input  logic      pop1,
    input  main_cnt_t main_almost_full_thr,
    input  main_cnt_t main_almost_empty_thr,
    input  out_cnt_t  out_almost_full_thr,   // keep at most out_depth - 1
    input  out_cnt_t  out_almost_empty_thr,
    output main_cnt_t main_count,
    output logic      main_full,
    output logic      main_empty,
    output logic      main_almost_full,
    output logic      main_almost_empty,
    output logic      main_error,
    output data_t     data_out0,
    output data_t     data_out1,
    output logic      out0_empty,
    output logic      out1_empty,
    output logic      out0_almost_empty,
    output logic      out1_almost_empty,
    output logic      out0_error,
    output logic      out1_error
);

    packet_t main_head;
    logic    main_pop;
    logic    push0;
    logic    push1;
    data_t   data0;
    data_t   data1;
    logic    out0_almost_full;
    logic    out1_almost_full;

    // input side
    fifo #(
        .payload_t (packet_t),
        .depth     (main_depth),
        .cnt_t     (main_cnt_t)
    ) u_main (
        .clk              (clk),
        .reset_L          (reset_L),
        .write            (push_in),
        .read             (main_pop),
        .buff_in          (packet_in),
        .umb_almost_full  (main_almost_full_thr),
        .umb_almost_empty (main_almost_empty_thr),
        .buff_out         (main_head),
        .data_count       (main_count),
        .fifo_full        (main_full),
        .fifo_empty       (main_empty),
        .almost_full      (main_almost_full),
        .almost_empty     (main_almost_empty),
        .error_cond       (main_error)
    );

    class_demux u_demux (
        .clk              (clk),
        .reset_L          (reset_L),
        .main_empty       (main_empty),
        .head             (main_head),
        .out0_almost_full (out0_almost_full),
        .out1_almost_full (out1_almost_full),
        .main_pop         (main_pop),
        .push0            (push0),
        .push1            (push1),
        .data0            (data0),
        .data1            (data1)
    );

    // output side, count and full stay internal
    fifo #(
        .payload_t (data_t),
        .depth     (out_depth),
        .cnt_t     (out_cnt_t)
    ) u_out0 (
        .clk              (clk),
        .reset_L          (reset_L),
        .write            (push0),
        .read             (pop0),
        .buff_in          (data0),
        .umb_almost_full  (out_almost_full_thr),
        .umb_almost_empty (out_almost_empty_thr),
        .buff_out         (data_out0),
        .data_count       (),
        .fifo_full        (),
        .fifo_empty       (out0_empty),
        .almost_full      (out0_almost_full),
        .almost_empty     (out0_almost_empty),
        .error_cond       (out0_error)
    );

    fifo #(
        .payload_t (data_t),
        .depth     (out_depth),
        .cnt_t     (out_cnt_t)
    ) u_out1 (
        .clk              (clk),
        .reset_L          (reset_L),
        .write            (push1),
        .read             (pop1),
        .buff_in          (data1),
        .umb_almost_full  (out_almost_full_thr),
        .umb_almost_empty (out_almost_empty_thr),
        .buff_out         (data_out1),
        .data_count       (),
        .fifo_full        (),
        .fifo_empty       (out1_empty),
        .almost_full      (out1_almost_full),
        .almost_empty     (out1_almost_empty),
        .error_cond       (out1_error)
    );

endmodule

// File: source/class_demux.sv
`timescale 1ns/1ns

module class_demux import router_pkg::*; (
    input  logic    clk,
    input  logic    reset_L,
    input  logic    main_empty,
    input  packet_t head,              // main FIFO output register
    input  logic    out0_almost_full,
    input  logic    out1_almost_full,
    output logic    main_pop,
    output logic    push0,
    output logic    push1,
    output data_t   data0,
    output data_t   data1
);

    logic stall;      // back-pressure from either output queue
    logic in_flight;  // head holds a word popped last cycle

    // any almost full output stops the whole input side
    assign stall = out0_almost_full || out1_almost_full;

    assign main_pop = !main_empty && !stall;

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            in_flight <= 1'b0;
        end else begin
            in_flight <= main_pop;
        end
    end

    // head is valid the cycle after the pop, steer it by dest
    always_comb begin
        push0 = 1'b0;
        push1 = 1'b0;
        if (in_flight) begin
            if (head.dest) begin
                push1 = 1'b1;
            end else begin
                push0 = 1'b1;
            end
        end
    end

    // both queues see the same word, only one gets the strobe
    assign data0 = head.data;
    assign data1 = head.data;

    a_one_target: assert property (
        @(posedge clk) disable iff (!reset_L)
        !(push0 && push1)
    ) else $error("demux pushed both output queues");

endmodule

// File: source/fifo.sv
`timescale 1ns/1ns

module fifo import router_pkg::*; #(
    parameter type payload_t = packet_t,
    parameter int  depth     = main_depth,
    parameter type cnt_t     = main_cnt_t
) (
    input  logic     clk,
    input  logic     reset_L,
    input  logic     write,
    input  logic     read,
    input  payload_t buff_in,
    input  cnt_t     umb_almost_full,   // almost full when count >= this
    input  cnt_t     umb_almost_empty,  // almost empty when 0 < count <= this
    output payload_t buff_out,
    output cnt_t     data_count,
    output logic     fifo_full,
    output logic     fifo_empty,
    output logic     almost_full,
    output logic     almost_empty,
    output logic     error_cond
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    typedef logic [ptr_w-1:0] ptr_t;

    localparam ptr_t last_ptr = ptr_t'(depth - 1);
    localparam cnt_t full_cnt = cnt_t'(depth);

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    logic wr_ok;  // push that the queue takes
    logic rd_ok;  // pop that the queue takes

    // pointers wrap at depth, which need not be a power of two
    function automatic ptr_t bump(input ptr_t p);
        ptr_t nxt;
        nxt = (p == last_ptr) ? '0 : ptr_t'(p + 1'b1);
        return nxt;
    endfunction

    assign wr_ok = write && !fifo_full;
    assign rd_ok = read && !fifo_empty;

    // flags straight from the count register
    always_comb begin
        fifo_full    = (data_count == full_cnt);
        fifo_empty   = (data_count == '0);
        almost_full  = (data_count >= umb_almost_full);
        almost_empty = (data_count != '0) && (data_count <= umb_almost_empty);
        // push on full or pop on empty, dropped this cycle
        error_cond   = (write && fifo_full) || (read && fifo_empty);
    end

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            data_count <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (rd_ok) begin
                rd_ptr <= bump(rd_ptr);
            end
            case ({wr_ok, rd_ok})
                2'b10:   data_count <= data_count + 1'b1;
                2'b01:   data_count <= data_count - 1'b1;
                default: data_count <= data_count;  // idle or push with pop
            endcase
        end
    end

    // head word lands in the memory read register at the pop edge
    ram_memory #(
        .payload_t (payload_t),
        .depth     (depth)
    ) u_mem (
        .clk      (clk),
        .reset_L  (reset_L),
        .write    (wr_ok),
        .read     (rd_ok),
        .wr_ptr   (wr_ptr),
        .rd_ptr   (rd_ptr),
        .data_in  (buff_in),
        .data_out (buff_out)
    );

    a_count_bound: assert property (
        @(posedge clk) disable iff (!reset_L)
        data_count <= full_cnt
    ) else $error("fifo count %0d above depth %0d", data_count, depth);

    // one push or one pop per cycle at most
    a_count_step: assert property (
        @(posedge clk) disable iff (!reset_L)
        $past(reset_L) |->
            (data_count == $past(data_count)) ||
            (data_count == cnt_t'($past(data_count) + 1'b1)) ||
            (data_count == cnt_t'($past(data_count) - 1'b1))
    ) else $error("fifo count jumped from %0d to %0d", $past(data_count), data_count);

endmodule

// File: source/ram_memory.sv
`timescale 1ns/1ns

module ram_memory #(
    parameter type payload_t = logic,
    parameter int  depth     = 4
) (
    input  logic                                      clk,
    input  logic                                      reset_L,
    input  logic                                      write,
    input  logic                                      read,
    input  logic [((depth > 1) ? $clog2(depth) : 1)-1:0] wr_ptr,
    input  logic [((depth > 1) ? $clog2(depth) : 1)-1:0] rd_ptr,
    input  payload_t                                  data_in,
    output payload_t                                  data_out
);

    payload_t mem [depth];

    // write port
    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // registered read port, holds its word between reads
    always_ff @(posedge clk) begin
        if (!reset_L) begin
            data_out <= '0;
        end else if (read) begin
            data_out <= mem[rd_ptr];
        end
    end

endmodule

// File: source/router_pkg.sv
package router_pkg;

    // data field width of every packet
    localparam int data_w = 5;

    // queue depths
    localparam int main_depth = 8;  // input side
    localparam int out_depth  = 4;  // each output side queue

    // counts must hold 0 up to the full depth
    typedef logic [$clog2(main_depth + 1)-1:0] main_cnt_t;  // 4 bits
    typedef logic [$clog2(out_depth + 1)-1:0]  out_cnt_t;   // 3 bits

    // payload seen by the output FIFOs
    typedef logic [data_w-1:0] data_t;

    // payload seen by the main FIFO, dest picks the output queue
    typedef struct packed {
        logic  dest;
        data_t data;
    } packet_t;

endpackage
